//--- id_stage.f
+incdir+design
design/cpu_types_pkg.sv
design/decode_pkg.sv
design/fetch_unpack.sv
design/id_type_r.sv
design/id_type_i.sv
design/decode_lane.sv
design/issue_pack.sv
design/id_stage.sv
bench/id_stage_tb.sv

//--- bench/id_stage_tb.sv
`include "cpu_config.svh"

module id_stage_tb;
	import cpu_types_pkg::*;
	import decode_pkg::*;

	localparam int LATENCY = 3;  // feeder, lane and collector registers

	typedef struct packed {
		Bit_t      valid;
		Oper_t     op;
		RegAddr_t  raddr1;
		RegAddr_t  raddr2;
		RegAddr_t  waddr;
		Bit_t      we;
		Word_t     imm;
	} lane_exp_t;

	typedef struct packed {
		Word_t                         pc;
		Inst_t [`ISSUE_WIDTH-1:0]      inst;
		Count_t                        count;
		lane_exp_t [`ISSUE_WIDTH-1:0]  lane;
		logic [`ISSUE_WIDTH-1:0]       raw_dep;
		Bit_t                          exc_valid;
		Word_t                         exc_pc;
	} entry_t;

	logic           clk;
	logic           rst_n;
	fetch_bundle_t  fetch;
	Bit_t           fetch_valid;
	issue_bundle_t  issue;
	Bit_t           issue_valid;

	entry_t  tbl [$];
	int      exp_q [$];     // entry index per strobe, in issue order
	int      strobe_q [$];  // cycle of each strobe
	int      cyc = 0;
	int      limit = 0;
	int      mismatches = 0;
	int      pass_cnt = 0;
	int      fail_cnt = 0;
	int      done_cnt = 0;
	integer  seed = 32'h9c407168;

	id_stage id_stage_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.fetch       (fetch),
		.fetch_valid (fetch_valid),
		.issue       (issue),
		.issue_valid (issue_valid)
	);

	always #20 clk = ~clk;

	function automatic Inst_t enc_r(input logic [5:0] opc, input RegAddr_t rs, input RegAddr_t rt,
		input RegAddr_t rd, input logic [4:0] sh, input logic [5:0] fn);
		return {opc, rs, rt, rd, sh, fn};
	endfunction

	function automatic Inst_t enc_i(input logic [5:0] opc, input RegAddr_t rs, input RegAddr_t rt,
		input logic [15:0] imm16);
		return {opc, rs, rt, imm16};
	endfunction

	function automatic Inst_t enc_j(input logic [5:0] opc, input logic [25:0] target);
		return {opc, target};
	endfunction

	function automatic lane_exp_t lx(input Bit_t v, input Oper_t op, input RegAddr_t r1,
		input RegAddr_t r2, input RegAddr_t wa, input Bit_t we, input Word_t imm);
		return '{valid: v, op: op, raddr1: r1, raddr2: r2, waddr: wa, we: we, imm: imm};
	endfunction

	task automatic add_entry(input Word_t pc, input Inst_t i0, input Inst_t i1, input int cnt,
		input lane_exp_t l0, input lane_exp_t l1, input logic [1:0] dep, input Bit_t xv,
		input Word_t xpc);
		entry_t e;
		e.pc        = pc;
		e.inst[0]   = i0;
		e.inst[1]   = i1;
		e.count     = Count_t'(cnt);
		e.lane[0]   = l0;
		e.lane[1]   = l1;
		e.raw_dep   = dep;
		e.exc_valid = xv;
		e.exc_pc    = xpc;
		tbl.push_back(e);
	endtask

	task automatic compare_oper(input Oper_t got, input Oper_t exp, input string what);
		if (got !== exp)
		begin
			$display("FAIL %0t: %s got %s expected %s", $time, what, got.name(), exp.name());
			mismatches++;
		end
	endtask

	task automatic compare_addr(input RegAddr_t got, input RegAddr_t exp, input string what);
		if (got !== exp)
		begin
			$display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
			mismatches++;
		end
	endtask

	task automatic compare_word(input Word_t got, input Word_t exp, input string what);
		if (got !== exp)
		begin
			$display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
			mismatches++;
		end
	endtask

	task automatic compare_bit(input Bit_t got, input Bit_t exp, input string what);
		if (got !== exp)
		begin
			$display("FAIL %0t: %s got %0b expected %0b", $time, what, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_bundle(input int idx, input int lat);
		entry_t     e;
		lane_exp_t  x;
		string      tag;
		int         bad_before;
		e          = tbl[idx];
		bad_before = mismatches;
		if (lat != LATENCY)
		begin
			$display("FAIL %0t: entry %0d issued %0d cycles after strobe", $time, idx, lat);
			mismatches++;
		end
		for (int k = 0; k < `ISSUE_WIDTH; k++)
		begin
			x   = e.lane[k];
			tag = $sformatf("entry %0d lane %0d", idx, k);
			compare_bit(issue.lane[k].valid, x.valid, {tag, " valid"});
			compare_bit(issue.raw_dep[k], e.raw_dep[k], {tag, " raw_dep"});
			if (x.valid)
			begin
				compare_word(issue.lane[k].pc, e.pc + Word_t'(k * `PC_STEP), {tag, " pc"});
				compare_oper(issue.lane[k].op, x.op, {tag, " op"});
				compare_bit(issue.lane[k].we, x.we, {tag, " we"});
				if (x.op != OP_INVALID)  // fields of an undecodable word are don't care
				begin
					compare_addr(issue.lane[k].raddr1, x.raddr1, {tag, " raddr1"});
					compare_addr(issue.lane[k].raddr2, x.raddr2, {tag, " raddr2"});
					compare_addr(issue.lane[k].waddr, x.waddr, {tag, " waddr"});
					compare_word(issue.lane[k].imm, x.imm, {tag, " imm"});
				end
			end
		end
		compare_bit(issue.exc_valid, e.exc_valid, $sformatf("entry %0d exc_valid", idx));
		compare_word(issue.exc_pc, e.exc_pc, $sformatf("entry %0d exc_pc", idx));
		if (mismatches == bad_before)
		begin
			pass_cnt++;
			$display("entry %0d ok", idx);
		end
		else
		begin
			fail_cnt++;
			$display("entry %0d bad, %0d mismatches", idx, mismatches - bad_before);
		end
	endtask

	// cycle counter and run limit
	always @(posedge clk)
	begin
		cyc++;
		if (cyc > limit)
		begin
			$display("timeout after %0d cycles, %0d of %0d bundles issued", cyc, done_cnt,
				tbl.size());
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// outputs sampled mid-cycle
	always @(negedge clk)
	begin
		if (issue_valid)
		begin
			if (exp_q.size() == 0)
			begin
				$display("issue_valid at time %0t with no bundle outstanding", $time);
				fail_cnt++;
			end
			else
			begin
				check_bundle(exp_q.pop_front(), cyc - strobe_q.pop_front());
				done_cnt++;
			end
		end
	end

	initial
	begin
		int gap;
		clk         = 1'b0;
		rst_n       = 1'b0;
		fetch       = '0;
		fetch_valid = 1'b0;

		// R-type: logical, shift, move, multiply, trap, SPECIAL2, COP0
		add_entry(32'h1000, enc_r(0, 1, 2, 3, 0, 6'h24), enc_r(0, 4, 5, 6, 0, 6'h25), 2,
			lx(1, OP_AND, 1, 2, 3, 1, 0), lx(1, OP_OR, 4, 5, 6, 1, 0), 2'b00, 0, 0);
		add_entry(32'h1008, enc_r(0, 0, 9, 8, 4, 6'h00), enc_r(0, 0, 0, 10, 0, 6'h10), 2,
			lx(1, OP_SLL, 0, 9, 8, 1, 0), lx(1, OP_MFHI, 0, 0, 10, 1, 0), 2'b00, 0, 0);
		add_entry(32'h1010, enc_r(0, 1, 2, 0, 0, 6'h18), enc_r(0, 3, 4, 0, 0, 6'h34), 2,
			lx(1, OP_MULT, 1, 2, 0, 0, 0), lx(1, OP_TEQ, 3, 4, 0, 0, 0), 2'b00, 0, 0);
		add_entry(32'h1018, enc_r(0, 6, 7, 5, 0, 6'h0b), enc_r(6'h1c, 12, 13, 11, 0, 6'h02), 2,
			lx(1, OP_MOVN, 6, 7, 5, 1, 0), lx(1, OP_MUL, 12, 13, 11, 1, 0), 2'b00, 0, 0);
		add_entry(32'h1020, enc_r(6'h1c, 15, 14, 14, 0, 6'h20), enc_r(6'h10, 0, 2, 12, 0, 0), 2,
			lx(1, OP_CLZ, 15, 0, 14, 1, 0), lx(1, OP_MFC0, 0, 0, 2, 1, 0), 2'b00, 0, 0);
		add_entry(32'h1028, enc_r(6'h10, 4, 3, 12, 0, 0), enc_r(6'h10, 5'h10, 0, 0, 0, 6'h18), 2,
			lx(1, OP_MTC0, 0, 3, 0, 0, 0), lx(1, OP_ERET, 0, 0, 0, 0, 0), 2'b00, 0, 0);
		add_entry(32'h1030, enc_r(0, 0, 0, 0, 0, 0), enc_r(0, 0, 0, 0, 0, 6'h0c), 2,
			lx(1, OP_NOP, 0, 0, 0, 0, 0), lx(1, OP_SYSCALL, 0, 0, 0, 0, 0), 2'b00, 0, 0);
		// I-type and J-type, lane 1 depends on lane 0 where marked
		add_entry(32'h2000, enc_i(6'h08, 5, 4, 16'hfffd), enc_i(6'h0d, 4, 6, 16'h8001), 2,
			lx(1, OP_ADDI, 5, 0, 4, 1, 32'hfffffffd), lx(1, OP_ORI, 4, 0, 6, 1, 32'h8001),
			2'b10, 0, 0);
		add_entry(32'h2008, enc_i(6'h0f, 0, 7, 16'h1234), enc_i(6'h23, 7, 8, 16'hfff8), 2,
			lx(1, OP_LUI, 0, 0, 7, 1, 32'h12340000), lx(1, OP_LW, 7, 0, 8, 1, 32'hfffffff8),
			2'b10, 0, 0);
		add_entry(32'h2010, enc_i(6'h2b, 10, 9, 16'h0010), enc_i(6'h04, 9, 10, 16'hfffc), 2,
			lx(1, OP_SW, 10, 9, 0, 0, 32'h10), lx(1, OP_BEQ, 9, 10, 0, 0, 32'hfffffffc),
			2'b00, 0, 0);
		add_entry(32'h2018, enc_i(6'h01, 3, 0, 16'h0020), enc_i(6'h01, 3, 1, 16'h8000), 2,
			lx(1, OP_BLTZ, 3, 0, 0, 0, 32'h20), lx(1, OP_BGEZ, 3, 0, 0, 0, 32'hffff8000),
			2'b00, 0, 0);
		add_entry(32'h2020, enc_j(6'h02, 26'h0123456), enc_j(6'h03, 26'h3ffffff), 2,
			lx(1, OP_J, 0, 0, 0, 0, 32'h00123456), lx(1, OP_JAL, 0, 0, 31, 1, 32'h03ffffff),
			2'b00, 0, 0);
		add_entry(32'h2028, enc_i(6'h0c, 1, 2, 16'hffff), enc_i(6'h0e, 2, 3, 16'h00f0), 2,
			lx(1, OP_ANDI, 1, 0, 2, 1, 32'hffff), lx(1, OP_XORI, 2, 0, 3, 1, 32'hf0),
			2'b10, 0, 0);
		// writing register 0 is no dependency
		add_entry(32'h2030, enc_i(6'h09, 5, 0, 16'h0001), enc_r(0, 0, 2, 1, 0, 6'h21), 2,
			lx(1, OP_ADDIU, 5, 0, 0, 1, 1), lx(1, OP_ADDU, 0, 2, 1, 1, 0), 2'b00, 0, 0);
		// single slot bundle
		add_entry(32'h2100, enc_r(0, 5, 6, 4, 0, 6'h22), enc_r(0, 4, 7, 8, 0, 6'h20), 1,
			lx(1, OP_SUB, 5, 6, 4, 1, 0), lx(0, OP_ADD, 4, 7, 8, 1, 0), 2'b00, 0, 0);
		// undecodable word in lane 0, then in lane 1
		add_entry(32'h3000, enc_i(6'h3f, 0, 0, 16'h0000), enc_r(0, 4, 5, 6, 0, 6'h25), 2,
			lx(1, OP_INVALID, 0, 0, 0, 0, 0), lx(0, OP_OR, 4, 5, 6, 1, 0), 2'b00, 1, 32'h3000);
		add_entry(32'h3100, enc_r(0, 2, 3, 1, 0, 6'h20), enc_r(0, 0, 0, 0, 0, 6'h3f), 2,
			lx(1, OP_ADD, 2, 3, 1, 1, 0), lx(1, OP_INVALID, 0, 0, 0, 0, 0), 2'b00, 1, 32'h3104);

		limit = tbl.size() * 4 + LATENCY + 20;

		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;
		for (int i = 0; i < tbl.size(); i++)
		begin
			fetch.pc    = tbl[i].pc;
			fetch.inst  = tbl[i].inst;
			fetch.count = tbl[i].count;
			fetch_valid = 1'b1;
			exp_q.push_back(i);
			strobe_q.push_back(cyc);
			@(posedge clk);
			#2;
			fetch_valid = 1'b0;
			gap = $unsigned($random(seed)) % 4;
			if (i % 4 == 1)
				gap = 0;  // keep some strobes back to back
			repeat (gap)
			begin
				@(posedge clk);
				#2;
			end
		end

		while (done_cnt < tbl.size())
			@(posedge clk);
		repeat (4) @(posedge clk);  // catch a stray issue_valid

		$display("summary: %0d entries ok, %0d bad", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && pass_cnt == tbl.size())
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- design/id_stage.sv
`include "cpu_config.svh"

module id_stage (
	input  logic                       clk,
	input  logic                       rst_n,
	input  decode_pkg::fetch_bundle_t  fetch,
	input  cpu_types_pkg::Bit_t        fetch_valid,
	output decode_pkg::issue_bundle_t  issue,
	output cpu_types_pkg::Bit_t        issue_valid
);
	import decode_pkg::*;

	fetch_slot_t [`ISSUE_WIDTH-1:0]  slot;
	decoded_t    [`ISSUE_WIDTH-1:0]  dec;

	fetch_unpack fetch_unpack_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.fetch       (fetch),
		.fetch_valid (fetch_valid),
		.slot        (slot)
	);

	for (genvar k = 0; k < `ISSUE_WIDTH; k++)
	begin : g_lane
		decode_lane decode_lane_inst (
			.clk   (clk),
			.rst_n (rst_n),
			.slot  (slot[k]),
			.dec   (dec[k])
		);
	end

	issue_pack issue_pack_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.dec         (dec),
		.issue       (issue),
		.issue_valid (issue_valid)
	);

endmodule

//--- design/issue_pack.sv
`include "cpu_config.svh"

module issue_pack (
	input  logic                                     clk,
	input  logic                                     rst_n,
	input  decode_pkg::decoded_t [`ISSUE_WIDTH-1:0]  dec,
	output decode_pkg::issue_bundle_t                issue,
	output cpu_types_pkg::Bit_t                      issue_valid
);
	import cpu_types_pkg::*;
	import decode_pkg::*;

	issue_bundle_t  issue_next;
	Bit_t           hit;  // an older lane already faulted

	always_comb
	begin
		issue_next = '0;
		hit        = 1'b0;
		for (int k = 0; k < `ISSUE_WIDTH; k++)
		begin
			issue_next.lane[k] = dec[k];
			if (hit)
				issue_next.lane[k].valid = 1'b0;  // squashed
			else if (dec[k].valid && dec[k].op == OP_INVALID)
			begin
				hit                  = 1'b1;
				issue_next.exc_valid = 1'b1;
				issue_next.exc_pc    = dec[k].pc;
			end
		end
		// raw check only between surviving lanes
		for (int k = 1; k < `ISSUE_WIDTH; k++)
		begin
			for (int j = 0; j < `ISSUE_WIDTH; j++)
			begin
				if (j < k && issue_next.lane[j].valid && issue_next.lane[k].valid &&
					issue_next.lane[j].we && issue_next.lane[j].waddr != '0 &&
					(issue_next.lane[j].waddr == issue_next.lane[k].raddr1 ||
					issue_next.lane[j].waddr == issue_next.lane[k].raddr2))
					issue_next.raw_dep[k] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			issue       <= '0;
			issue_valid <= 1'b0;
		end
		else
		begin
			issue       <= issue_next;
			issue_valid <= dec[0].valid;  // lane 0 always present
		end
	end

	exc_needs_issue: assert property (@(posedge clk) disable iff (!rst_n)
		issue.exc_valid |-> issue_valid);

endmodule

//--- design/decode_lane.sv
module decode_lane (
	input  logic                     clk,
	input  logic                     rst_n,
	input  decode_pkg::fetch_slot_t  slot,
	output decode_pkg::decoded_t     dec
);
	import cpu_types_pkg::*;
	import decode_pkg::*;

	logic [5:0]  opcode;
	Bit_t        is_r;
	RegAddr_t    r_raddr1, r_raddr2, r_waddr;
	RegAddr_t    i_raddr1, i_raddr2, i_waddr;
	Bit_t        r_we, i_we;
	Oper_t       r_op, i_op;
	Word_t       i_imm;
	decoded_t    dec_next;

	assign opcode = slot.inst[31:26];
	// SPECIAL, SPECIAL2, COP0
	assign is_r = (opcode == 6'b000000) || (opcode == 6'b011100) || (opcode == 6'b010000);

	id_type_r id_type_r_inst (
		.opcode     (opcode),
		.inst       (slot.inst),
		.reg_raddr1 (r_raddr1),
		.reg_raddr2 (r_raddr2),
		.reg_waddr  (r_waddr),
		.reg_we     (r_we),
		.op         (r_op)
	);

	id_type_i id_type_i_inst (
		.opcode     (opcode),
		.inst       (slot.inst),
		.reg_raddr1 (i_raddr1),
		.reg_raddr2 (i_raddr2),
		.reg_waddr  (i_waddr),
		.reg_we     (i_we),
		.op         (i_op),
		.imm        (i_imm)
	);

	always_comb
	begin
		dec_next.valid  = slot.valid;
		dec_next.pc     = slot.pc;
		dec_next.op     = is_r ? r_op : i_op;
		dec_next.raddr1 = is_r ? r_raddr1 : i_raddr1;
		dec_next.raddr2 = is_r ? r_raddr2 : i_raddr2;
		dec_next.waddr  = is_r ? r_waddr : i_waddr;
		dec_next.imm    = is_r ? '0 : i_imm;
		dec_next.we     = (is_r ? r_we : i_we) && (dec_next.op != OP_INVALID);
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			dec <= '0;
		else
			dec <= dec_next;
	end

	// i decoder keeps an unknown opcode from writing on its own
	no_write_on_invalid: assert property (@(posedge clk) disable iff (!rst_n)
		(slot.valid && !is_r) |-> !(i_we && i_op == OP_INVALID));

endmodule

//--- design/id_type_i.sv
`include "cpu_config.svh"

module id_type_i (
	input  logic [5:0]               opcode,
	input  cpu_types_pkg::Inst_t     inst,
	output cpu_types_pkg::RegAddr_t  reg_raddr1,
	output cpu_types_pkg::RegAddr_t  reg_raddr2,
	output cpu_types_pkg::RegAddr_t  reg_waddr,
	output cpu_types_pkg::Bit_t      reg_we,
	output cpu_types_pkg::Oper_t     op,
	output cpu_types_pkg::Word_t     imm
);
	import cpu_types_pkg::*;

	RegAddr_t  rs;
	RegAddr_t  rt;
	Word_t     simm;
	Word_t     zimm;
	Word_t     jimm;

	assign rs   = inst[25:21];
	assign rt   = inst[20:16];
	assign simm = {{(`WORD_W-16){inst[15]}}, inst[15:0]};
	assign zimm = Word_t'(inst[15:0]);
	assign jimm = Word_t'(inst[25:0]);  // target field, unshifted

	always_comb
	begin
		op = OP_INVALID;
		case (opcode)
			6'b001000: op = OP_ADDI;
			6'b001001: op = OP_ADDIU;
			6'b001010: op = OP_SLTI;
			6'b001011: op = OP_SLTIU;
			6'b001100: op = OP_ANDI;
			6'b001101: op = OP_ORI;
			6'b001110: op = OP_XORI;
			6'b001111: op = OP_LUI;
			6'b100000: op = OP_LB;
			6'b100100: op = OP_LBU;
			6'b100001: op = OP_LH;
			6'b100101: op = OP_LHU;
			6'b100011: op = OP_LW;
			6'b101000: op = OP_SB;
			6'b101001: op = OP_SH;
			6'b101011: op = OP_SW;
			6'b000100: op = OP_BEQ;
			6'b000101: op = OP_BNE;
			6'b000110: op = OP_BLEZ;
			6'b000111: op = OP_BGTZ;
			6'b000001:  // REGIMM, link forms not handled
			begin
				if (rt == 5'b00000)
					op = OP_BLTZ;
				else if (rt == 5'b00001)
					op = OP_BGEZ;
			end
			6'b000010: op = OP_J;
			6'b000011: op = OP_JAL;
			default:   op = OP_INVALID;
		endcase
	end

	always_comb
	begin
		reg_raddr1 = rs;
		reg_raddr2 = '0;
		reg_waddr  = rt;  // loads and alu-imm write rt
		reg_we     = 1'b1;
		imm        = simm;
		case (op)
			OP_ANDI, OP_ORI, OP_XORI:
				imm = zimm;
			OP_LUI:
			begin
				reg_raddr1 = '0;
				imm        = Word_t'({inst[15:0], 16'b0});
			end
			OP_SB, OP_SH, OP_SW, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ:
			begin
				reg_raddr2 = rt;
				reg_we     = 1'b0;
			end
			OP_BLTZ, OP_BGEZ, OP_INVALID:
				reg_we = 1'b0;
			OP_J:
			begin
				reg_raddr1 = '0;
				reg_we     = 1'b0;
				imm        = jimm;
			end
			OP_JAL:
			begin
				reg_raddr1 = '0;
				reg_waddr  = RegAddr_t'(31);  // ra
				imm        = jimm;
			end
			default: ;
		endcase
		if (!reg_we)
			reg_waddr = '0;
	end

endmodule

//--- design/id_type_r.sv
module id_type_r (
	input  logic [5:0]               opcode,
	input  cpu_types_pkg::Inst_t     inst,
	output cpu_types_pkg::RegAddr_t  reg_raddr1,
	output cpu_types_pkg::RegAddr_t  reg_raddr2,
	output cpu_types_pkg::RegAddr_t  reg_waddr,
	output cpu_types_pkg::Bit_t      reg_we,
	output cpu_types_pkg::Oper_t     op
);
	import cpu_types_pkg::*;

	RegAddr_t    rs;
	RegAddr_t    rt;
	RegAddr_t    rd;
	logic [5:0]  funct;

	assign rs    = inst[25:21];
	assign rt    = inst[20:16];
	assign rd    = inst[15:11];
	assign funct = inst[5:0];

	function automatic Oper_t special_op(input logic [5:0] f);
		case (f)
			6'b100100: return OP_AND;
			6'b100101: return OP_OR;
			6'b100110: return OP_XOR;
			6'b100111: return OP_NOR;
			6'b010000: return OP_MFHI;
			6'b010001: return OP_MTHI;
			6'b010010: return OP_MFLO;
			6'b010011: return OP_MTLO;
			6'b001011: return OP_MOVN;
			6'b001010: return OP_MOVZ;
			6'b001000: return OP_JR;
			6'b001001: return OP_JALR;
			6'b000000: return OP_SLL;
			6'b000010: return OP_SRL;
			6'b000011: return OP_SRA;
			6'b000100: return OP_SLLV;
			6'b000110: return OP_SRLV;
			6'b000111: return OP_SRAV;
			6'b100000: return OP_ADD;
			6'b100001: return OP_ADDU;
			6'b100010: return OP_SUB;
			6'b100011: return OP_SUBU;
			6'b011000: return OP_MULT;
			6'b011001: return OP_MULTU;
			6'b101010: return OP_SLT;
			6'b101011: return OP_SLTU;
			6'b110000: return OP_TGE;
			6'b110001: return OP_TGEU;
			6'b110010: return OP_TLT;
			6'b110011: return OP_TLTU;
			6'b110100: return OP_TEQ;
			6'b110110: return OP_TNE;
			6'b001100: return OP_SYSCALL;
			6'b001101: return OP_BREAK;
			6'b001111: return OP_NOP;  // sync
			default:   return OP_INVALID;
		endcase
	endfunction

	always_comb
	begin
		op = OP_INVALID;
		case (opcode)
			6'b000000: op = (inst == '0) ? OP_NOP : special_op(funct);
			6'b011100:  // SPECIAL2
				case (funct)
					6'b100000: op = OP_CLZ;
					6'b100001: op = OP_CLO;
					6'b000000: op = OP_MADD;
					6'b000001: op = OP_MADDU;
					6'b000100: op = OP_MSUB;
					6'b000101: op = OP_MSUBU;
					6'b000010: op = OP_MUL;
					default:   op = OP_INVALID;
				endcase
			6'b010000:  // COP0, selected by rs
				case (rs)
					5'b00000: op = OP_MFC0;
					5'b00100: op = OP_MTC0;
					5'b10000: op = (funct == 6'b011000) ? OP_ERET : OP_INVALID;
					default:  op = OP_INVALID;
				endcase
			default: op = OP_INVALID;
		endcase
	end

	// register usage follows the operation
	always_comb
	begin
		reg_raddr1 = rs;
		reg_raddr2 = rt;
		reg_waddr  = rd;
		reg_we     = 1'b1;
		case (op)
			OP_NOP, OP_SYSCALL, OP_BREAK:
			begin
				reg_raddr1 = '0;
				reg_raddr2 = '0;
				reg_we     = 1'b0;
			end
			OP_MTHI, OP_MTLO, OP_JR, OP_MULT, OP_MULTU,
			OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU,
			OP_TGE, OP_TGEU, OP_TLT, OP_TLTU, OP_TEQ, OP_TNE:
				reg_we = 1'b0;  // hi/lo or trap only
			OP_CLZ, OP_CLO:
				reg_raddr2 = '0;
			OP_MFC0:
			begin
				reg_raddr1 = '0;
				reg_raddr2 = '0;
				reg_waddr  = rt;
			end
			OP_MTC0, OP_ERET:
			begin
				reg_raddr1 = '0;
				reg_we     = 1'b0;
			end
			default: ;
		endcase
		if (!reg_we)
			reg_waddr = '0;
	end

endmodule

//--- design/fetch_unpack.sv
`include "cpu_config.svh"

module fetch_unpack (
	input  logic                                        clk,
	input  logic                                        rst_n,
	input  decode_pkg::fetch_bundle_t                   fetch,
	input  cpu_types_pkg::Bit_t                         fetch_valid,
	output decode_pkg::fetch_slot_t [`ISSUE_WIDTH-1:0]  slot
);
	import cpu_types_pkg::*;
	import decode_pkg::*;

	fetch_bundle_t  bundle_q;
	Bit_t           valid_q;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			valid_q <= 1'b0;
		else
			valid_q <= fetch_valid;
	end

	always_ff @(posedge clk)
	begin
		if (fetch_valid)
			bundle_q <= fetch;  // held until the next strobe
	end

	always_comb
	begin
		for (int k = 0; k < `ISSUE_WIDTH; k++)
		begin
			slot[k].valid = valid_q && (k < bundle_q.count);
			slot[k].pc    = bundle_q.pc + Word_t'(k * `PC_STEP);
			slot[k].inst  = bundle_q.inst[k];
		end
	end

	// fetch must never hand over an empty or oversized bundle
	count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		fetch_valid |-> (fetch.count != '0 && fetch.count <= `ISSUE_WIDTH));

endmodule

//--- design/decode_pkg.sv
`include "cpu_config.svh"

package decode_pkg;
	import cpu_types_pkg::*;

	typedef logic [$clog2(`ISSUE_WIDTH + 1)-1:0] Count_t;  // valid slots in a bundle

	typedef struct packed {
		Word_t                     pc;     // pc of slot 0
		Inst_t [`ISSUE_WIDTH-1:0]  inst;
		Count_t                    count;  // 1 to ISSUE_WIDTH
	} fetch_bundle_t;

	typedef struct packed {
		Bit_t   valid;
		Word_t  pc;
		Inst_t  inst;
	} fetch_slot_t;

	typedef struct packed {
		Bit_t      valid;
		Word_t     pc;
		Oper_t     op;
		RegAddr_t  raddr1;
		RegAddr_t  raddr2;
		RegAddr_t  waddr;
		Bit_t      we;
		Word_t     imm;
	} decoded_t;

	typedef struct packed {
		decoded_t [`ISSUE_WIDTH-1:0]  lane;
		logic [`ISSUE_WIDTH-1:0]      raw_dep;  // reads an older lane's result
		Bit_t                         exc_valid;
		Word_t                        exc_pc;
	} issue_bundle_t;

endpackage

//--- design/cpu_types_pkg.sv
`include "cpu_config.svh"

package cpu_types_pkg;

	typedef logic [31:0]              Inst_t;     // raw instruction word
	typedef logic [`WORD_W-1:0]       Word_t;     // pc and immediates
	typedef logic [`REG_ADDR_W-1:0]   RegAddr_t;  // gpr number
	typedef logic                     Bit_t;

	// every operation either decoder can emit
	typedef enum logic [6:0] {
		// SPECIAL, SPECIAL2 and COP0 forms
		OP_NOP,
		OP_AND, OP_OR, OP_XOR, OP_NOR,
		OP_MFHI, OP_MTHI, OP_MFLO, OP_MTLO,
		OP_MOVN, OP_MOVZ,
		OP_JR, OP_JALR,
		OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
		OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
		OP_MULT, OP_MULTU,
		OP_SLT, OP_SLTU,
		OP_TGE, OP_TGEU, OP_TLT, OP_TLTU, OP_TEQ, OP_TNE,
		OP_SYSCALL, OP_BREAK,
		OP_CLZ, OP_CLO,
		OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU,
		OP_MUL,
		OP_MFC0, OP_MTC0, OP_ERET,
		// immediate ALU
		OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
		OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
		// memory
		OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
		OP_SB, OP_SH, OP_SW,
		// branch and jump
		OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
		OP_BLTZ, OP_BGEZ,
		OP_J, OP_JAL,
		OP_INVALID
	} Oper_t;

endpackage

//--- design/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// decode lanes per fetch bundle
`define ISSUE_WIDTH 2

// data path and pc width
`define WORD_W 32

// architectural register number
`define REG_ADDR_W 5

// byte distance between consecutive slots
`define PC_STEP 4

`endif
